/* vlog.f */
+incdir+hw
hw/core_pkgs.sv
hw/pipe_ifs.sv
hw/control_unit.sv
hw/reg_bank.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/wb_stage.sv
hw/rv_core_top.sv
tests/tb_clkgen.sv
tests/core_checker.sv
tests/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_rv_core
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

/* tests/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
	import riscv_isa_pkg::*;
	import core_pipe_pkg::*;

	logic        clk;
	logic        reset_i;
	logic        instr_valid_i;
	instr_t      instruction_i;
	logic        wb_valid_o;
	reg_addr_t   wb_rd_o;
	word_t       wb_data_o;
	logic        illegal_o;
	retire_cnt_t retired_o;

	// stimulus / expectation table
	instr_t      q_ins[$];
	logic        q_vld[$];
	reg_addr_t   q_rd[$];
	word_t       q_data[$];
	logic        q_ill[$];
	word_t       model_regs [32];
	retire_cnt_t retire_exp;

	tb_clkgen clkgen (.clk_o(clk));

	rv_core_top DUT (
		.clk           (clk),
		.reset_i       (reset_i),
		.instr_valid_i (instr_valid_i),
		.instruction_i (instruction_i),
		.wb_valid_o    (wb_valid_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o),
		.illegal_o     (illegal_o),
		.retired_o     (retired_o)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_run($sformatf("Error: t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			stop_run($sformatf("Error: t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Error: t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input retire_cnt_t got,
			input retire_cnt_t exp);
		if (got !== exp)
			stop_run($sformatf("Error: t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
			reg_addr_t rs1, reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic instr_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
			logic [11:0] imm);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic instr_t enc_u(reg_addr_t rd, logic [19:0] imm);
		return {imm, rd, LUI};
	endfunction

	// RV32I integer ops by funct3 with alt selecting sub and sra
	function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_step(input instr_t ins, output reg_addr_t rd, output word_t data,
			output logic ill);
		word_t a;
		word_t imm;
		a    = model_regs[ins[19:15]];
		imm  = {{20{ins[31]}}, ins[31:20]};
		rd   = ins[11:7];
		ill  = 1'b0;
		data = '0;
		if (ins[6:0] == OP)
			data = alu_ref(ins[14:12], ins[30] && (ins[14:12] inside {3'd0, 3'd5}), a,
				model_regs[ins[24:20]]);
		else if (ins[6:0] == OP_IMM)
			data = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm);
		else if (ins[6:0] == LUI)
			data = {ins[31:12], 12'b0};
		else
			ill = 1'b1;
		if (!ill && rd != '0)
			model_regs[rd] = data;
	endtask

	// model tracks the table so the random phase starts from known state
	task automatic add_row(input instr_t ins, input logic v, input reg_addr_t rd,
			input word_t data, input logic ill);
		reg_addr_t m_rd;
		word_t     m_data;
		logic      m_ill;
		if (v)
			model_step(ins, m_rd, m_data, m_ill);
		q_ins.push_back(ins);
		q_vld.push_back(v);
		q_rd.push_back(rd);
		q_data.push_back(data);
		q_ill.push_back(ill);
	endtask

	task automatic build_table();
		add_row(enc_u(5'd1, 20'h12345), 1, 5'd1, 32'h12345000, 0);
		add_row(enc_i(3'd0, 5'd2, 5'd0, 12'hffb), 1, 5'd2, 32'hfffffffb, 0);
		add_row(enc_i(3'd0, 5'd3, 5'd1, 12'h678), 1, 5'd3, 32'h12345678, 0);
		add_row(enc_r(7'h00, 3'd0, 5'd4, 5'd3, 5'd2), 1, 5'd4, 32'h12345673, 0);
		add_row(enc_r(7'h20, 3'd0, 5'd5, 5'd4, 5'd3), 1, 5'd5, 32'hfffffffb, 0);
		add_row(enc_r(7'h00, 3'd2, 5'd6, 5'd2, 5'd3), 1, 5'd6, 32'd1, 0);   // slt
		add_row(enc_r(7'h00, 3'd3, 5'd7, 5'd2, 5'd3), 1, 5'd7, 32'd0, 0);   // sltu
		add_row(enc_i(3'd2, 5'd8, 5'd2, 12'hffc), 1, 5'd8, 32'd1, 0);
		add_row(enc_i(3'd3, 5'd9, 5'd2, 12'hfff), 1, 5'd9, 32'd1, 0);
		add_row(enc_r(7'h00, 3'd4, 5'd10, 5'd1, 5'd2), 1, 5'd10, 32'hedcbaffb, 0);
		add_row(enc_i(3'd4, 5'd11, 5'd3, 12'h0ff), 1, 5'd11, 32'h12345687, 0);
		add_row(enc_r(7'h00, 3'd6, 5'd12, 5'd1, 5'd3), 1, 5'd12, 32'h12345678, 0);
		add_row(enc_i(3'd6, 5'd13, 5'd0, 12'h7f0), 1, 5'd13, 32'h000007f0, 0);
		add_row(enc_r(7'h00, 3'd7, 5'd14, 5'd3, 5'd13), 1, 5'd14, 32'h00000670, 0);
		add_row(enc_i(3'd7, 5'd15, 5'd3, 12'h0f0), 1, 5'd15, 32'h00000070, 0);
		add_row(enc_i(3'd1, 5'd16, 5'd3, 12'h004), 1, 5'd16, 32'h23456780, 0);
		add_row(enc_i(3'd5, 5'd17, 5'd2, 12'h004), 1, 5'd17, 32'h0fffffff, 0);
		add_row(enc_i(3'd5, 5'd18, 5'd2, 12'h401), 1, 5'd18, 32'hfffffffd, 0);   // srai
		add_row(enc_i(3'd0, 5'd19, 5'd0, 12'h003), 1, 5'd19, 32'd3, 0);
		add_row(enc_r(7'h00, 3'd1, 5'd20, 5'd3, 5'd19), 1, 5'd20, 32'h91a2b3c0, 0);
		add_row(enc_r(7'h00, 3'd5, 5'd21, 5'd2, 5'd19), 1, 5'd21, 32'h1fffffff, 0);
		add_row(enc_r(7'h20, 3'd5, 5'd22, 5'd2, 5'd19), 1, 5'd22, 32'hffffffff, 0);
		add_row(32'h00000183, 1, 5'd0, 32'd0, 1);   // load to x3, illegal
		add_row(enc_i(3'd0, 5'd5, 5'd0, 12'h001), 0, 5'd0, 32'd0, 0);   // empty slot
		add_row(enc_i(3'd0, 5'd0, 5'd1, 12'h005), 1, 5'd0, 32'h12345005, 0);
		add_row(enc_r(7'h00, 3'd0, 5'd23, 5'd0, 5'd0), 1, 5'd23, 32'd0, 0);
		add_row(enc_r(7'h00, 3'd0, 5'd24, 5'd22, 5'd21), 1, 5'd24, 32'h1ffffffe, 0);
		add_row(enc_i(3'd0, 5'd25, 5'd3, 12'h000), 1, 5'd25, 32'h12345678, 0);
	endtask

	task automatic add_random_row();
		instr_t     ins;
		logic [2:0] f3;
		logic       alt;
		reg_addr_t  rd;
		word_t      data;
		logic       ill;
		f3  = 3'($urandom_range(0, 7));
		alt = 1'($urandom_range(0, 1)) && (f3 == 3'd0 || f3 == 3'd5);
		case ($urandom_range(0, 9))
			0: ins = enc_u(5'($urandom), 20'($urandom));
			1, 2, 3, 4: ins = enc_r({1'b0, alt, 5'b0}, f3, 5'($urandom), 5'($urandom),
				5'($urandom));
			default: begin
				ins = enc_i(f3, 5'($urandom), 5'($urandom), 12'($urandom));
				if (f3 == 3'd1 || f3 == 3'd5)
					ins[31:25] = {1'b0, alt && f3 == 3'd5, 5'b0};
			end
		endcase
		model_step(ins, rd, data, ill);
		q_ins.push_back(ins);
		q_vld.push_back(1'b1);
		q_rd.push_back(rd);
		q_data.push_back(data);
		q_ill.push_back(ill);
	endtask

	task automatic check_row(input int i);
		logic exp_valid;
		exp_valid = q_vld[i] && !q_ill[i];
		check_bit("wb_valid_o", wb_valid_o, exp_valid);
		check_bit("illegal_o", illegal_o, q_vld[i] && q_ill[i]);
		if (exp_valid) begin
			check_reg("wb_rd_o", wb_rd_o, q_rd[i]);
			check_word("wb_data_o", wb_data_o, q_data[i]);
			retire_exp++;
		end
		check_count("retired_o", retired_o, retire_exp);
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		while (wb_valid_o !== 1'b0 || illegal_o !== 1'b0 || retired_o !== '0) begin
			@(negedge clk);
			cnt++;
			if (cnt > 20)
				stop_run("outputs did not go idle after reset");
		end
	endtask

	initial begin
		for (int wd = 0; wd < 5000; wd++)
			@(posedge clk);
		stop_run("watchdog expired, simulation did not finish");
	end

	initial begin
		int n;
		void'($urandom(19));
		reset_i       = 1'b1;
		instr_valid_i = 1'b0;
		instruction_i = '0;
		retire_exp    = '0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		for (int c = 0; c < 8; c++)
			@(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		wait_idle();
		build_table();
		for (int r = 0; r < 200; r++)
			add_random_row();
		n = q_ins.size();
		// result of row i shows up three edges after it is driven
		for (int i = 0; i < n + 3; i++) begin
			@(posedge clk);
			if (i < n) begin
				instr_valid_i <= q_vld[i];
				instruction_i <= q_ins[i];
			end else begin
				instr_valid_i <= 1'b0;
			end
			@(negedge clk);
			if (i >= 3)
				check_row(i - 3);
		end
		// pipeline drained, nothing more retires
		@(posedge clk);
		@(negedge clk);
		check_bit("wb_valid_o", wb_valid_o, 1'b0);
		check_bit("illegal_o", illegal_o, 1'b0);
		check_count("retired_o", retired_o, retire_exp);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/core_checker.sv */
`default_nettype none

module core_checker (
	input logic                       clk_i,
	input logic                       reset_i,
	input logic                       wb_valid_i,
	input riscv_isa_pkg::reg_addr_t   wb_rd_i,
	input logic                       illegal_i,
	input core_pipe_pkg::retire_cnt_t retired_i
);
	a_valid_xor_illegal: assert property (@(posedge clk_i) disable iff (reset_i)
		!(wb_valid_i && illegal_i))
		else $error("wb_valid_o and illegal_o high together");

	// a reported result to x0 must still be counted as retired
	a_x0_retired: assert property (@(posedge clk_i) disable iff (reset_i)
		(wb_valid_i && wb_rd_i == '0) |-> retired_i == $past(retired_i) + 1'b1)
		else $error("x0 result reported without retirement");

	a_count_monotonic: assert property (@(posedge clk_i) disable iff (reset_i)
		1'b1 |=> (retired_i == $past(retired_i) || retired_i == $past(retired_i) + 1'b1))
		else $error("retired_o moved by more than one or went back");

	a_idle_after_reset: assert property (@(posedge clk_i)
		$fell(reset_i) |-> (!wb_valid_i && !illegal_i && retired_i == '0))
		else $error("outputs not cleared by reset");

endmodule

bind rv_core_top core_checker chk (
	.clk_i      (clk),
	.reset_i    (reset_i),
	.wb_valid_i (wb_valid_o),
	.wb_rd_i    (wb_rd_o),
	.illegal_i  (illegal_o),
	.retired_i  (retired_o)
);

`default_nettype wire

/* tests/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
	output logic clk_o
);
	initial begin
		clk_o = 1'b0;
	end

	always #4 clk_o = ~clk_o;   // period 8

endmodule

`default_nettype wire

/* hw/rv_core_top.sv */
`default_nettype none

module rv_core_top (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       instr_valid_i,
	input  riscv_isa_pkg::instr_t      instruction_i,
	output logic                       wb_valid_o,
	output riscv_isa_pkg::reg_addr_t   wb_rd_o,
	output riscv_isa_pkg::word_t       wb_data_o,
	output logic                       illegal_o,
	output core_pipe_pkg::retire_cnt_t retired_o
);
	import riscv_isa_pkg::*;

	// result stage back into the register bank
	reg_addr_t reg_waddr;
	word_t     reg_wdata;
	logic      reg_wen;

	id_ex_if id_ex ();
	ex_wb_if ex_wb ();

	id_stage id_stg (
		.clk           (clk),
		.reset_i       (reset_i),
		.instr_valid_i (instr_valid_i),
		.instruction_i (instruction_i),
		.reg_waddr_i   (reg_waddr),
		.reg_wdata_i   (reg_wdata),
		.reg_wen_i     (reg_wen),
		.ex            (id_ex.producer),
		.fwd           (ex_wb.bypass)
	);

	ex_stage ex_stg (
		.clk     (clk),
		.reset_i (reset_i),
		.id      (id_ex.consumer),
		.wb      (ex_wb.producer)
	);

	wb_stage wb_stg (
		.clk         (clk),
		.reset_i     (reset_i),
		.ex          (ex_wb.consumer),
		.reg_waddr_o (reg_waddr),
		.reg_wdata_o (reg_wdata),
		.reg_wen_o   (reg_wen),
		.wb_valid_o  (wb_valid_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o),
		.illegal_o   (illegal_o),
		.retired_o   (retired_o)
	);

endmodule

`default_nettype wire

/* hw/wb_stage.sv */
`default_nettype none

module wb_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	ex_wb_if.consumer                  ex,
	output riscv_isa_pkg::reg_addr_t   reg_waddr_o,
	output riscv_isa_pkg::word_t       reg_wdata_o,
	output logic                       reg_wen_o,
	output logic                       wb_valid_o,
	output riscv_isa_pkg::reg_addr_t   wb_rd_o,
	output riscv_isa_pkg::word_t       wb_data_o,
	output logic                       illegal_o,
	output core_pipe_pkg::retire_cnt_t retired_o
);
	import core_pipe_pkg::*;

	logic retire;

	assign retire = ex.valid & ~ex.illegal;   // x0 targets count too

	// write port, commits at the next edge
	assign reg_waddr_o = ex.rd;
	assign reg_wdata_o = ex.result;
	assign reg_wen_o   = ex.valid & ex.wen;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
			illegal_o  <= 1'b0;
			retired_o  <= '0;
		end else begin
			wb_valid_o <= retire;
			illegal_o  <= ex.valid & ex.illegal;
			if (retire)
				retired_o <= retired_o + retire_cnt_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		wb_rd_o   <= ex.rd;
		wb_data_o <= ex.result;
	end

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`default_nettype none

module ex_stage (
	input  logic       clk,
	input  logic       reset_i,
	id_ex_if.consumer  id,
	ex_wb_if.producer  wb
);
	import riscv_isa_pkg::*;
	import core_pipe_pkg::*;

	word_t      alu_out;
	logic [4:0] shamt;

	assign shamt = id.op_b[4:0];

	always_comb begin
		case (id.alu_op)
			ALU_ADD:    alu_out = id.op_a + id.op_b;
			ALU_SUB:    alu_out = id.op_a - id.op_b;
			ALU_SLL:    alu_out = id.op_a << shamt;
			ALU_SLT:    alu_out = word_t'($signed(id.op_a) < $signed(id.op_b));
			ALU_SLTU:   alu_out = word_t'(id.op_a < id.op_b);
			ALU_XOR:    alu_out = id.op_a ^ id.op_b;
			ALU_SRL:    alu_out = id.op_a >> shamt;
			ALU_SRA:    alu_out = $signed(id.op_a) >>> shamt;
			ALU_OR:     alu_out = id.op_a | id.op_b;
			ALU_AND:    alu_out = id.op_a & id.op_b;
			ALU_PASS_B: alu_out = id.op_b;
			default:    alu_out = '0;
		endcase
	end

	// distance-1 bypass into decode
	assign id.ex_result = alu_out;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb.valid   <= 1'b0;
			wb.wen     <= 1'b0;
			wb.illegal <= 1'b0;
		end else begin
			wb.valid   <= id.valid;
			wb.wen     <= id.wen;
			wb.illegal <= id.illegal;
		end
	end

	always_ff @(posedge clk) begin
		wb.rd     <= id.rd;
		wb.result <= alu_out;
	end

endmodule

`default_nettype wire

/* hw/id_stage.sv */
`default_nettype none

module id_stage (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     instr_valid_i,
	input  riscv_isa_pkg::instr_t    instruction_i,
	input  riscv_isa_pkg::reg_addr_t reg_waddr_i,
	input  riscv_isa_pkg::word_t     reg_wdata_i,
	input  logic                     reg_wen_i,
	id_ex_if.producer                ex,
	ex_wb_if.bypass                  fwd
);
	import riscv_isa_pkg::*;
	import core_pipe_pkg::*;

	reg_addr_t     rs1_addr;
	reg_addr_t     rs2_addr;
	word_t         bank_a;
	word_t         bank_b;
	word_t         src_a;
	word_t         src_b;
	alu_op_e       alu_op;
	word_t         imm;
	logic          use_imm;
	reg_addr_t     rd;
	logic          dec_wen;
	decoded_opcode instr_type;

	assign rs1_addr = instruction_i[19:15];
	assign rs2_addr = instruction_i[24:20];

	reg_bank regbank (
		.clk          (clk),
		.reset_i      (reset_i),
		.read_addr1_i (rs1_addr),
		.read_addr2_i (rs2_addr),
		.write_addr_i (reg_waddr_i),
		.write_data_i (reg_wdata_i),
		.write_en_i   (reg_wen_i),
		.read_data1_o (bank_a),
		.read_data2_o (bank_b)
	);

	control_unit ctrl_unit (
		.instruction_i (instruction_i),
		.alu_op_o      (alu_op),
		.imm_o         (imm),
		.use_imm_o     (use_imm),
		.rd_o          (rd),
		.wen_o         (dec_wen),
		.instr_type_o  (instr_type)
	);

	// youngest producer wins: alu output, then ex_wb, then the bank
	always_comb begin
		if (ex.wen && ex.rd == rs1_addr)
			src_a = ex.ex_result;
		else if (fwd.wen && fwd.rd == rs1_addr)
			src_a = fwd.result;
		else
			src_a = bank_a;

		if (ex.wen && ex.rd == rs2_addr)
			src_b = ex.ex_result;
		else if (fwd.wen && fwd.rd == rs2_addr)
			src_b = fwd.result;
		else
			src_b = bank_b;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex.valid   <= 1'b0;
			ex.wen     <= 1'b0;
			ex.illegal <= 1'b0;
		end else begin
			ex.valid   <= instr_valid_i;
			ex.wen     <= instr_valid_i & dec_wen;   // empty slot writes nothing
			ex.illegal <= instr_valid_i & (instr_type == ILLEGAL);
		end
	end

	always_ff @(posedge clk) begin
		ex.alu_op <= alu_op;
		ex.op_a   <= src_a;
		ex.op_b   <= use_imm ? imm : src_b;
		ex.rd     <= rd;
	end

endmodule

`default_nettype wire

/* hw/reg_bank.sv */
`default_nettype none

`include "core_defines.svh"

module reg_bank (
	input  logic                     clk,
	input  logic                     reset_i,
	input  riscv_isa_pkg::reg_addr_t read_addr1_i,
	input  riscv_isa_pkg::reg_addr_t read_addr2_i,
	input  riscv_isa_pkg::reg_addr_t write_addr_i,
	input  riscv_isa_pkg::word_t     write_data_i,
	input  logic                     write_en_i,
	output riscv_isa_pkg::word_t     read_data1_o,
	output riscv_isa_pkg::word_t     read_data2_o
);
	import riscv_isa_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (write_en_i) begin
			regs[write_addr_i] <= write_data_i;   // x0 never gets a wen
		end
	end

	assign read_data1_o = regs[read_addr1_i];
	assign read_data2_o = regs[read_addr2_i];

endmodule

`default_nettype wire

/* hw/control_unit.sv */
`default_nettype none

module control_unit (
	input  riscv_isa_pkg::instr_t        instruction_i,
	output core_pipe_pkg::alu_op_e       alu_op_o,
	output riscv_isa_pkg::word_t         imm_o,
	output logic                         use_imm_o,
	output riscv_isa_pkg::reg_addr_t     rd_o,
	output logic                         wen_o,
	output riscv_isa_pkg::decoded_opcode instr_type_o
);
	import riscv_isa_pkg::*;
	import core_pipe_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       funct7_b5;
	word_t      imm_i;
	word_t      imm_u;
	alu_op_e    func_op;

	assign opcode    = opcode_e'(instruction_i[6:0]);
	assign funct3    = instruction_i[14:12];
	assign funct7_b5 = instruction_i[30];   // sub / sra select
	assign rd_o      = instruction_i[11:7];

	assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
	assign imm_u = {instruction_i[31:12], 12'b0};

	// funct3 mapping, same for OP and OP-IMM
	always_comb begin
		case (funct3)
			3'b000:  func_op = ALU_ADD;
			3'b001:  func_op = ALU_SLL;
			3'b010:  func_op = ALU_SLT;
			3'b011:  func_op = ALU_SLTU;
			3'b100:  func_op = ALU_XOR;
			3'b101:  func_op = funct7_b5 ? ALU_SRA : ALU_SRL;
			3'b110:  func_op = ALU_OR;
			default: func_op = ALU_AND;
		endcase
	end

	always_comb begin
		instr_type_o = ILLEGAL;
		alu_op_o     = ALU_ADD;
		imm_o        = imm_i;
		use_imm_o    = 1'b0;
		case (opcode)
			OP: begin
				instr_type_o = R_TYPE;
				// only the register form has sub
				if (funct3 == 3'b000 && funct7_b5)
					alu_op_o = ALU_SUB;
				else
					alu_op_o = func_op;
			end
			OP_IMM: begin
				instr_type_o = I_ALU;
				alu_op_o     = func_op;
				use_imm_o    = 1'b1;
			end
			LUI: begin
				instr_type_o = U_LUI;
				alu_op_o     = ALU_PASS_B;
				imm_o        = imm_u;
				use_imm_o    = 1'b1;
			end
			default: begin
				instr_type_o = ILLEGAL;   // no pc, no memory
			end
		endcase
	end

	// the one place x0 is filtered out
	assign wen_o = (instr_type_o != ILLEGAL) && (rd_o != '0);

endmodule

`default_nettype wire

/* hw/pipe_ifs.sv */
`default_nettype none

// decode -> execute
interface id_ex_if;
	import riscv_isa_pkg::*;
	import core_pipe_pkg::*;

	logic      valid;
	alu_op_e   alu_op;
	word_t     op_a;
	word_t     op_b;
	reg_addr_t rd;
	logic      wen;
	logic      illegal;
	word_t     ex_result;   // alu output, back to decode

	modport producer (output valid, alu_op, op_a, op_b, rd, wen, illegal, input ex_result);
	modport consumer (input valid, alu_op, op_a, op_b, rd, wen, illegal, output ex_result);
endinterface

// execute -> result, also tapped by decode for forwarding
interface ex_wb_if;
	import riscv_isa_pkg::*;

	logic      valid;
	reg_addr_t rd;
	word_t     result;
	logic      wen;
	logic      illegal;

	modport producer (output valid, rd, result, wen, illegal);
	modport consumer (input valid, rd, result, wen, illegal);
	modport bypass (input rd, result, wen);
endinterface

`default_nettype wire

/* hw/core_pkgs.sv */
`default_nettype none

`include "core_defines.svh"

package riscv_isa_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [31:0] instr_t;

	// major opcodes, bits 6:0
	typedef enum logic [6:0] {
		LOAD     = 7'b0000011,
		MISC_MEM = 7'b0001111,
		OP_IMM   = 7'b0010011,
		AUIPC    = 7'b0010111,
		STORE    = 7'b0100011,
		OP       = 7'b0110011,
		LUI      = 7'b0110111,
		BRANCH   = 7'b1100011,
		JALR     = 7'b1100111,
		JAL      = 7'b1101111,
		SYSTEM   = 7'b1110011
	} opcode_e;

	// what the core actually executes
	typedef enum logic [1:0] {
		R_TYPE,
		I_ALU,
		U_LUI,
		ILLEGAL
	} decoded_opcode;

endpackage

package core_pipe_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B   // lui
	} alu_op_e;

	typedef logic [15:0] retire_cnt_t;

endpackage

`default_nettype wire

/* hw/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath word
`define WORD_WIDTH 32

// register index bits
`define ADDR_WIDTH 5

`define NUM_REGS 32

`endif
